// ==== verilog/mem_pkg.sv ====
// shared widths and enums for the memory stage, imported by the RTL and the testbench
package mem_pkg;

    localparam int xlen   = 32; // data and address width
    localparam int strb_w = 4;  // byte lanes per word

    // load/store width, encoded as funct3
    typedef enum logic [2:0] {
        lsw_b  = 3'b000,
        lsw_h  = 3'b001,
        lsw_w  = 3'b010,
        lsw_bu = 3'b100,
        lsw_hu = 3'b101
    } ls_width_e;

    typedef enum logic [1:0] {
        st_idle, // empty
        st_hold, // non-load or written store, waiting on out_ready
        st_read, // load in flight
        st_done  // load data captured
    } stage_state_e;

endpackage

// ==== verilog/data_sram.sv ====
// word-wide data memory with byte-strobed writes and a fixed-latency read channel
module data_sram
    import mem_pkg::*;
#(
    parameter int mem_words    = 1024,
    parameter int read_latency = 2
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              ar_valid,
    input  logic [xlen-1:0]   ar_addr,
    output logic              ar_ready,

    output logic              r_valid,
    output logic [xlen-1:0]   r_data,
    input  logic              r_ready,

    input  logic              w_en,
    input  logic [xlen-1:0]   w_addr,
    input  logic [xlen-1:0]   w_data,
    input  logic [strb_w-1:0] w_strb
);
    localparam int aw = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [xlen-1:0] mem [mem_words];
    logic [aw-1:0]   r_idx;
    logic [aw-1:0]   w_idx;
    logic            busy;  // one read outstanding
    logic [3:0]      cnt;   // cycles left until data

    // byte address to word index, wrapped to the depth
    function automatic logic [aw-1:0] word_index(input logic [xlen-1:0] addr);
        word_index = aw'(addr[xlen-1:2] % mem_words);
    endfunction

    assign r_idx    = word_index(ar_addr);
    assign w_idx    = word_index(w_addr);
    assign ar_ready = !busy;
    assign r_valid  = busy && (cnt == 4'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= 4'd0;
        end else begin
            if (ar_valid && ar_ready) begin
                busy <= 1'b1;
                cnt  <= 4'(read_latency - 1);
            end else if (r_valid && r_ready) begin
                busy <= 1'b0;
            end else if (busy && cnt != 4'd0) begin
                cnt <= cnt - 4'd1;
            end
        end
    end

    // array is sampled when the read is accepted
    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r_data <= mem[r_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (w_en) begin
            for (int i = 0; i < strb_w; i++) begin
                if (w_strb[i]) begin
                    mem[w_idx][8*i +: 8] <= w_data[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== verilog/store_format.sv ====
// store formatter: replicates store data into every lane and builds the byte strobe
module store_format
    import mem_pkg::*;
(
    input  ls_width_e         width,
    input  logic [1:0]        addr_low,
    input  logic [xlen-1:0]   rs2_value,
    output logic [xlen-1:0]   w_data,
    output logic [strb_w-1:0] w_strb
);

    always_comb begin
        w_data = rs2_value;
        w_strb = '0;
        case (width)
            lsw_b: begin
                w_data = {strb_w{rs2_value[7:0]}};
                w_strb = strb_w'(1) << addr_low;
            end
            lsw_h: begin
                w_data = {(strb_w/2){rs2_value[15:0]}};
                w_strb = strb_w'(3) << {addr_low[1], 1'b0}; // lanes 0-1 or 2-3
            end
            lsw_w: begin
                w_strb = '1;
            end
            default: begin
                w_strb = '0; // not a store width, nothing written
            end
        endcase
    end

endmodule

// ==== verilog/load_format.sv ====
// load formatter: selects the addressed byte or halfword and extends it to a full word
module load_format
    import mem_pkg::*;
(
    input  ls_width_e       width,
    input  logic [1:0]      addr_low,
    input  logic [xlen-1:0] r_data,
    output logic [xlen-1:0] load_data
);
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign lane_b = r_data[{addr_low, 3'b000} +: 8];
    assign lane_h = r_data[{addr_low[1], 4'b0000} +: 16]; // low bit ignored

    always_comb begin
        case (width)
            lsw_b: begin
                load_data = {{(xlen-8){lane_b[7]}}, lane_b};
            end
            lsw_h: begin
                load_data = {{(xlen-16){lane_h[15]}}, lane_h};
            end
            lsw_w: begin
                load_data = r_data;
            end
            lsw_bu: begin
                load_data = {{(xlen-8){1'b0}}, lane_b};
            end
            lsw_hu: begin
                load_data = {{(xlen-16){1'b0}}, lane_h};
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

endmodule

// ==== verilog/mem_stage.sv ====
// memory-access pipeline stage: holds one item and runs its load or store against the data memory
module mem_stage
    import mem_pkg::*;
#(
    parameter int mem_words    = 1024,
    parameter int read_latency = 2
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    output logic            in_ready,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] inst,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] csrs,
    input  logic [xlen-1:0] rs2_value,
    input  logic [4:0]      rd,
    input  logic [2:0]      funct3,
    input  logic            r_wen,
    input  logic [3:0]      csr_wen,
    input  logic            mem_ren,
    input  logic            mem_wen,
    input  logic            jump_flag,

    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] pc_out,
    output logic [xlen-1:0] inst_out,
    output logic [xlen-1:0] result_out,
    output logic [xlen-1:0] csrs_out,
    output logic [4:0]      rd_out,
    output logic            r_wen_out,
    output logic [3:0]      csr_wen_out,
    output logic            jump_flag_out
);
    stage_state_e      state;

    logic [xlen-1:0]   ex_result_q;
    logic [xlen-1:0]   rs2_value_q;
    logic [2:0]        funct3_q;
    logic              mem_ren_q;
    logic [xlen-1:0]   load_q;
    ls_width_e         width;
    logic              in_fire;

    logic              ar_valid;
    logic              ar_ready;
    logic              r_valid;
    logic              r_ready;
    logic [xlen-1:0]   r_data;
    logic [xlen-1:0]   load_data;
    logic              w_en;
    logic [xlen-1:0]   w_data;
    logic [strb_w-1:0] w_strb;

    assign out_valid  = (state == st_hold) || (state == st_done);
    assign in_ready   = (state == st_idle) || (out_valid && out_ready);
    assign in_fire    = in_valid && in_ready;
    assign r_ready    = (state == st_read);
    assign width      = ls_width_e'(funct3_q);
    assign result_out = mem_ren_q ? load_q : ex_result_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= st_idle;
            ar_valid <= 1'b0;
            w_en     <= 1'b0;
        end else begin
            w_en <= in_fire && mem_wen && !mem_ren; // single pulse per store
            if (in_fire) begin
                state    <= mem_ren ? st_read : st_hold;
                ar_valid <= mem_ren;
            end else begin
                case (state)
                    st_read: begin
                        if (ar_valid && ar_ready) begin
                            ar_valid <= 1'b0;
                        end
                        if (r_valid && r_ready) begin
                            state <= st_done;
                        end
                    end
                    st_hold, st_done: begin
                        if (out_ready) begin
                            state <= st_idle;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // item fields, loaded on accept
    always_ff @(posedge clk) begin
        if (in_fire) begin
            pc_out        <= pc;
            inst_out      <= inst;
            csrs_out      <= csrs;
            rd_out        <= rd;
            r_wen_out     <= r_wen;
            csr_wen_out   <= csr_wen;
            jump_flag_out <= jump_flag;
            ex_result_q   <= ex_result;
            rs2_value_q   <= rs2_value;
            funct3_q      <= funct3;
            mem_ren_q     <= mem_ren;
        end
        if (r_valid && r_ready) begin
            load_q <= load_data;
        end
    end

    data_sram #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) u_sram (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_addr  (ex_result_q),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_data   (r_data),
        .r_ready  (r_ready),
        .w_en     (w_en),
        .w_addr   (ex_result_q),
        .w_data   (w_data),
        .w_strb   (w_strb)
    );

    store_format u_store_fmt (
        .width     (width),
        .addr_low  (ex_result_q[1:0]),
        .rs2_value (rs2_value_q),
        .w_data    (w_data),
        .w_strb    (w_strb)
    );

    load_format u_load_fmt (
        .width     (width),
        .addr_low  (ex_result_q[1:0]),
        .r_data    (r_data),
        .load_data (load_data)
    );

endmodule

// ==== verilog/mem_subsystem.sv ====
// memory subsystem top: fixes memory depth and read latency and wraps the stage
module mem_subsystem
    import mem_pkg::*;
#(
    parameter int mem_words    = 1024,
    parameter int read_latency = 2   // 1 to 8
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    output logic            in_ready,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] inst,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] csrs,
    input  logic [xlen-1:0] rs2_value,
    input  logic [4:0]      rd,
    input  logic [2:0]      funct3,
    input  logic            r_wen,
    input  logic [3:0]      csr_wen,
    input  logic            mem_ren,
    input  logic            mem_wen,
    input  logic            jump_flag,

    output logic            out_valid,
    input  logic            out_ready,
    output logic [xlen-1:0] pc_out,
    output logic [xlen-1:0] inst_out,
    output logic [xlen-1:0] result_out,
    output logic [xlen-1:0] csrs_out,
    output logic [4:0]      rd_out,
    output logic            r_wen_out,
    output logic [3:0]      csr_wen_out,
    output logic            jump_flag_out
);

    mem_stage #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) u_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .pc            (pc),
        .inst          (inst),
        .ex_result     (ex_result),
        .csrs          (csrs),
        .rs2_value     (rs2_value),
        .rd            (rd),
        .funct3        (funct3),
        .r_wen         (r_wen),
        .csr_wen       (csr_wen),
        .mem_ren       (mem_ren),
        .mem_wen       (mem_wen),
        .jump_flag     (jump_flag),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .pc_out        (pc_out),
        .inst_out      (inst_out),
        .result_out    (result_out),
        .csrs_out      (csrs_out),
        .rd_out        (rd_out),
        .r_wen_out     (r_wen_out),
        .csr_wen_out   (csr_wen_out),
        .jump_flag_out (jump_flag_out)
    );

endmodule

// ==== test/tb_mem_subsystem.sv ====
// self-checking testbench that drives random pass-through, store and load items into the memory subsystem
module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int mem_words      = 1024;
    localparam int read_latency   = 2;
    localparam int accept_timeout = 200; // cycles
    localparam int drain_timeout  = 200;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] result;
        logic [31:0] csrs;
        logic [4:0]  rd;
        logic        r_wen;
        logic [3:0]  csr_wen;
        logic        jump_flag;
        logic        is_load;
        logic [31:0] cycle;    // edge count at acceptance
    } exp_item_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] ex_result;
    logic [31:0] csrs;
    logic [31:0] rs2_value;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic        r_wen;
    logic [3:0]  csr_wen;
    logic        mem_ren;
    logic        mem_wen;
    logic        jump_flag;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] pc_out;
    logic [31:0] inst_out;
    logic [31:0] result_out;
    logic [31:0] csrs_out;
    logic [4:0]  rd_out;
    logic        r_wen_out;
    logic [3:0]  csr_wen_out;
    logic        jump_flag_out;

    integer      seed       = 32'h7495a97d;
    integer      stall_seed = 32'h7495a97d;
    bit          stall_en   = 1'b0;
    bit          timed_out  = 1'b0;
    int          cycle      = 0;
    int          main_errors = 0;
    int          mon_errors  = 0;
    int          hold_errors = 0;
    int          accepted_count = 0;
    int          out_count      = 0;

    logic [7:0]  ref_mem [0:4095]; // byte model of the data memory
    exp_item_t   exp_q [$];
    string       name_q [$];

    bit          held = 1'b0;
    logic [138:0] held_fields;
    logic [138:0] out_now;
    exp_item_t   mon_item;
    string       mon_name;

    mem_subsystem #(
        .mem_words    (mem_words),
        .read_latency (read_latency)
    ) DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    assign out_now = {pc_out, inst_out, result_out, csrs_out, rd_out, r_wen_out,
                      csr_wen_out, jump_flag_out};

    function automatic logic [31:0] next_random();
        next_random = $random(seed);
    endfunction

    function automatic logic [2:0] width_code(input int unsigned k);
        case (k)
            0: width_code = lsw_b;
            1: width_code = lsw_h;
            2: width_code = lsw_w;
            3: width_code = lsw_bu;
            default: width_code = lsw_hu;
        endcase
    endfunction

    // little endian with halfword lanes starting at an even byte
    function automatic logic [31:0] predict_load(input logic [2:0] f3, input logic [11:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        logic [11:0] hbase;
        logic [11:0] wbase;
        hbase = {addr[11:1], 1'b0};
        wbase = {addr[11:2], 2'b00};
        b = ref_mem[addr];
        h = {ref_mem[hbase + 12'd1], ref_mem[hbase]};
        case (f3)
            lsw_b:   predict_load = {{24{b[7]}}, b};
            lsw_h:   predict_load = {{16{h[15]}}, h};
            lsw_bu:  predict_load = {24'd0, b};
            lsw_hu:  predict_load = {16'd0, h};
            lsw_w:   predict_load = {ref_mem[wbase + 12'd3], ref_mem[wbase + 12'd2],
                                     ref_mem[wbase + 12'd1], ref_mem[wbase]};
            default: predict_load = 32'd0;
        endcase
    endfunction

    function automatic void model_store(input logic [2:0] f3, input logic [11:0] addr,
                                        input logic [31:0] data);
        logic [11:0] hbase;
        logic [11:0] wbase;
        hbase = {addr[11:1], 1'b0};
        wbase = {addr[11:2], 2'b00};
        case (f3)
            lsw_b: ref_mem[addr] = data[7:0];
            lsw_h: begin
                ref_mem[hbase]         = data[7:0];
                ref_mem[hbase + 12'd1] = data[15:8];
            end
            lsw_w: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[wbase + 12'(i)] = data[8*i +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    function automatic int check_value(input string test, input string field,
                                       input logic [31:0] expected, input logic [31:0] actual);
        check_value = 0;
        assert (actual === expected) else begin
            check_value = 1;
            $display("Error %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endfunction

    // drives one item from 2 units after a rising edge and waits until it is accepted
    task automatic send_item(input string test, input logic [2:0] f3, input logic ren,
                             input logic wen, input logic [31:0] ex_value,
                             input logic [31:0] data);
        exp_item_t   e;
        logic [31:0] r;
        int          waited;
        bit          taken;
        if (!timed_out) begin
            r         = next_random();
            pc        = {r[31:2], 2'b00};
            inst      = next_random();
            csrs      = next_random();
            r         = next_random();
            rd        = r[4:0];
            r_wen     = r[5];
            csr_wen   = r[9:6];
            jump_flag = r[10];
            ex_result = ex_value;
            rs2_value = data;
            funct3    = f3;
            mem_ren   = ren;
            mem_wen   = wen;
            in_valid  = 1'b1;
            taken     = 1'b0;
            waited    = 0;
            while (!taken && waited < accept_timeout) begin
                @(negedge clk);
                taken = in_ready; // nothing changes before the next edge
                @(posedge clk);
                #2;
                waited++;
            end
            in_valid = 1'b0;
            if (taken) begin
                e = {pc, inst, 32'd0, csrs, rd, r_wen, csr_wen, jump_flag, ren, 32'(cycle)};
                e.result = ren ? predict_load(f3, ex_value[11:0]) : ex_value;
                if (wen && !ren) begin
                    model_store(f3, ex_value[11:0], data);
                end
                exp_q.push_back(e);
                name_q.push_back(test);
                accepted_count++;
            end else begin
                $display("timed out waiting for in_ready");
                main_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    // random out_ready stalls driven 2 units after the edge
    initial begin
        bit stall_now;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            stall_now = stall_en; // enable is only changed after the edge
            #2;
            if (stall_now) begin
                out_ready = ($random(stall_seed) & 32'h3) != 0;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    held_blocks_input: assert property (@(negedge clk) disable iff (!rst_n)
            !(out_valid && !out_ready && in_ready))
        else begin
            hold_errors++;
            $display("in_ready was high while a stalled item was held");
        end

    // output monitor sampling everything at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            held = 1'b0;
        end else begin
            if (held) begin
                assert (out_valid && out_now === held_fields) else begin
                    mon_errors++;
                    $display("Error backpressure hold: expected %h, actual %h",
                             {1'b1, held_fields}, {out_valid, out_now});
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    mon_errors++;
                    $display("an output appeared with no accepted item waiting for it");
                end else begin
                    mon_item = exp_q.pop_front();
                    mon_name = name_q.pop_front();
                    mon_errors += check_value(mon_name, "pc_out", mon_item.pc, pc_out);
                    mon_errors += check_value(mon_name, "inst_out", mon_item.inst, inst_out);
                    mon_errors += check_value(mon_name, "result_out", mon_item.result, result_out);
                    mon_errors += check_value(mon_name, "csrs_out", mon_item.csrs, csrs_out);
                    mon_errors += check_value(mon_name, "rd_out", 32'(mon_item.rd), 32'(rd_out));
                    mon_errors += check_value(mon_name, "r_wen_out", 32'(mon_item.r_wen),
                                              32'(r_wen_out));
                    mon_errors += check_value(mon_name, "csr_wen_out", 32'(mon_item.csr_wen),
                                              32'(csr_wen_out));
                    mon_errors += check_value(mon_name, "jump_flag_out", 32'(mon_item.jump_flag),
                                              32'(jump_flag_out));
                    if (mon_item.is_load) begin
                        assert (cycle + 1 >= mon_item.cycle + read_latency + 2) else begin
                            mon_errors++;
                            $display("%s: load finished before the memory read could return",
                                     mon_name);
                        end
                    end
                end
                out_count++;
            end
            held        = out_valid && !out_ready;
            held_fields = out_now;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        int          waited;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        pc        = '0;
        inst      = '0;
        ex_result = '0;
        csrs      = '0;
        rs2_value = '0;
        rd        = '0;
        funct3    = '0;
        r_wen     = 1'b0;
        csr_wen   = '0;
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        jump_flag = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        main_errors += check_value("reset", "out_valid", 32'd0, 32'(out_valid));
        main_errors += check_value("reset", "in_ready", 32'd1, 32'(in_ready));
        @(posedge clk);
        #2;

        for (int i = 0; i < 8; i++) begin
            r = next_random();
            send_item("pass_through", r[2:0], 1'b0, 1'b0, next_random(), next_random());
        end

        for (int i = 0; i < 8; i++) begin
            r    = next_random();
            addr = {20'd0, r[11:2], 2'b00};
            send_item("word_store_load", lsw_w, 1'b0, 1'b1, addr, next_random());
            send_item("word_store_load", lsw_w, 1'b1, 1'b0, addr, 32'd0);
        end

        // one byte store per lane and every lane read back
        for (int k = 0; k < 4; k++) begin
            addr = 32'h200 + 32'(4 * k);
            send_item("byte_store", lsw_w, 1'b0, 1'b1, addr, next_random());
            data    = next_random();
            data[7] = k[0];
            send_item("byte_store", lsw_b, 1'b0, 1'b1, addr + 32'(k), data);
            for (int j = 0; j < 4; j++) begin
                send_item("byte_load", lsw_b, 1'b1, 1'b0, addr + 32'(j), 32'd0);
                send_item("byte_load", lsw_bu, 1'b1, 1'b0, addr + 32'(j), 32'd0);
            end
            send_item("byte_store", lsw_w, 1'b1, 1'b0, addr, 32'd0);
        end
        for (int k = 0; k < 4; k++) begin
            addr = 32'h210 + 32'(4 * k);
            send_item("half_store", lsw_w, 1'b0, 1'b1, addr, next_random());
            data     = next_random();
            data[15] = ~k[1];
            send_item("half_store", lsw_h, 1'b0, 1'b1, addr + 32'(k), data);
            for (int j = 0; j < 4; j++) begin
                send_item("half_load", lsw_h, 1'b1, 1'b0, addr + 32'(j), 32'd0);
                send_item("half_load", lsw_hu, 1'b1, 1'b0, addr + 32'(j), 32'd0);
            end
            send_item("half_store", lsw_w, 1'b1, 1'b0, addr, 32'd0);
        end
        send_item("bad_width_load", 3'b011, 1'b1, 1'b0, 32'h200, 32'd0);

        for (int k = 0; k < 16; k++) begin
            send_item("backpressure_init", lsw_w, 1'b0, 1'b1, 32'h300 + 32'(4 * k), next_random());
        end
        stall_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            r    = next_random();
            addr = 32'h300 + {26'd0, r[5:0]};
            data = next_random();
            case (r[9:8])
                2'd0: send_item("backpressure", r[12:10], 1'b0, 1'b0, next_random(), data);
                2'd1: send_item("backpressure", width_code(r[31:16] % 3), 1'b0, 1'b1, addr, data);
                default: send_item("backpressure", width_code(r[31:16] % 5), 1'b1, 1'b0, addr, data);
            endcase
        end
        stall_en = 1'b0;

        waited = 0;
        while (out_count != accepted_count && waited < drain_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (out_count != accepted_count) begin
            $display("timed out waiting for out_valid");
            main_errors++;
        end
        main_errors += check_value("completion", "output count", 32'(accepted_count),
                                   32'(out_count));

        $display("errors: %0d, items accepted: %0d, items completed: %0d",
                 main_errors + mon_errors + hold_errors, accepted_count, out_count);
        if (main_errors + mon_errors + hold_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/mem_pkg.sv
verilog/data_sram.sv
verilog/store_format.sv
verilog/load_format.sv
verilog/mem_stage.sv
verilog/mem_subsystem.sv
test/tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
